/* sim.f */
+incdir+.
usb_pkg.sv
usb_line_sync.sv
usb_bit_timer.sv
usb_rx_fsm.sv
usb_nrzi_decoder.sv
usb_rx_fifo.sv
usb_wb_regs.sv
usb_rx_top.sv
usb_tb_clock.sv
usb_rx_properties.sv
usb_rx_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = usb_rx_tb
FILELIST  = sim.f
OBJDIR    = obj_dir
RUN_FLAGS = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)

/* usb_rx_tb.sv */
//**************************************************************************
// Host model sends full-speed packets, four clocks per bit, with NRZI and
// bit stuffing. Reads go over Wishbone classic, one cycle at a time.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "usb_params.svh"

module usb_rx_tb;

  localparam logic [31:0]           SEED        = 32'h954d8f20;
  localparam logic [`WB_ADDR_W-1:0] ADR_STATUS  = 0;
  localparam logic [`WB_ADDR_W-1:0] ADR_DATA    = 1;
  localparam int                    ACK_TIMEOUT = 16;  // clocks
  localparam int                    POLL_LIMIT  = 64;  // status reads
  localparam int                    RESET_LIMIT = 32;

  logic                  clk;
  logic                  reset;
  logic                  usb_p;
  logic                  usb_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`WB_ADDR_W-1:0] wb_adr;
  logic [`WB_DATA_W-1:0] wb_dat_w;
  logic [`WB_DATA_W-1:0] wb_dat_r;
  logic                  wb_ack;

  logic [7:0]  pkt [$];   // payload of the current packet
  logic [1:0]  line_now;  // host side line state
  int          ones_run;
  logic [31:0] rng;
  string       test_name;
  int          errors;
  int          test_errors;
  int          tests;
  int          failed;

  usb_tb_clock u_clock (.clk, .reset);

  usb_rx_top DUT (
    .clk, .reset, .usb_p, .usb_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
    .wb_dat_w, .wb_dat_r, .wb_ack
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] status_word(input int cnt, input logic last,
                                              input logic err, input logic ovf);
    usb_pkg::rx_status_t s;
    s           = '0;
    s.count     = 4'(cnt);
    s.nonempty  = (cnt != 0);
    s.head_last = last;
    s.head_err  = err;
    s.overflow  = ovf;
    return s;
  endfunction

  function automatic logic [31:0] entry_word(input logic [7:0] data, input logic last,
                                             input logic err);
    return {22'd0, err, last, data};  // data register layout
  endfunction

  task automatic report_failure(input string msg);
    $display("%s: %s", test_name, msg);
    errors++;
    test_errors++;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("** Error: %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test();
    tests++;
    if (test_errors == 0)
      $display("test %0d %s: passed", tests, test_name);
    else
    begin
      failed++;
      $display("test %0d %s: failed with %0d errors", tests, test_name, test_errors);
    end
    test_errors = 0;
  endtask

  // code held for the given bit times from the next edge
  task automatic drive_line(input logic [1:0] code, input int bits);
    @(posedge clk);
    usb_p <= code[1];
    usb_n <= code[0];
    repeat (`USB_OVERSAMPLE * bits - 1) @(posedge clk);
  endtask

  task automatic emit_bit(input logic b, input logic stuff);
    if (b)
      ones_run++;
    else
    begin
      line_now = ~line_now;  // J and K are bitwise inverses
      ones_run = 0;
    end
    drive_line(line_now, 1);
    if (stuff && ones_run == 6)
    begin
      line_now = ~line_now;  // stuffed zero
      ones_run = 0;
      drive_line(line_now, 1);
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    for (int i = 0; i < 8; i++)
      emit_bit(b[i], 1'b1);  // LSB first
  endtask

  task automatic begin_packet();
    line_now = `LINE_J;
    ones_run = 0;
    send_byte(8'h80);  // sync
  endtask

  task automatic end_packet();
    drive_line(`LINE_Z, 2);
    drive_line(`LINE_J, 4);  // EOP J plus idle gap
    line_now = `LINE_J;
  endtask

  task automatic send_packet();
    begin_packet();
    foreach (pkt[i])
      send_byte(pkt[i]);
    end_packet();
  endtask

  task automatic fill_random(input int n);
    pkt.delete();
    repeat (n)
    begin
      rng = xorshift32(rng);
      pkt.push_back(rng[7:0]);
    end
  endtask

  task automatic bus_cycle(input logic we, input logic [`WB_ADDR_W-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
    end
    while (!wb_ack && n < ACK_TIMEOUT);
    rdata = wb_dat_r;
    if (!wb_ack)
      report_failure($sformatf("no wishbone ack within %0d clocks", ACK_TIMEOUT));
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wait_count(input int want);
    logic [31:0]         rd;
    usb_pkg::rx_status_t st;
    int                  polls;
    polls = 0;
    do
    begin
      bus_cycle(1'b0, ADR_STATUS, '0, rd);
      st = rd;
      polls++;
    end
    while (st.count < want && polls < POLL_LIMIT);
    if (st.count < want)
      report_failure($sformatf("fifo never reached %0d entries", want));
  endtask

  task automatic read_packet(input int n, input logic last_on_end);
    logic [31:0] rd;
    for (int i = 0; i < n; i++)
    begin
      bus_cycle(1'b0, ADR_DATA, '0, rd);
      check_value($sformatf("entry %0d", i),
                  entry_word(pkt[i], last_on_end && (i == n - 1), 1'b0), rd);
    end
  endtask

  initial
  begin
    logic [31:0] rd;
    int          n;
    usb_p       = 1'b1;  // idle J
    usb_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    rng         = SEED;
    line_now    = `LINE_J;
    ones_run    = 0;
    errors      = 0;
    test_errors = 0;
    tests       = 0;
    failed      = 0;
    test_name   = "reset";
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
    end
    while (reset !== 1'b0 && n < RESET_LIMIT);
    if (reset !== 1'b0)
      report_failure("reset never released");
    drive_line(`LINE_J, 4);

    test_name = "reset_state";
    bus_cycle(1'b0, ADR_STATUS, '0, rd);
    check_value("status", status_word(0, 1'b0, 1'b0, 1'b0), rd);
    bus_cycle(1'b0, ADR_DATA, '0, rd);
    check_value("empty data read", '0, rd);
    @(posedge clk);
    check_value("ack after cycle", '0, {31'd0, wb_ack});
    finish_test();

    test_name = "random_packet";
    fill_random(4);
    send_packet();
    wait_count(4);
    read_packet(4, 1'b1);
    finish_test();

    test_name = "stuffed_bytes";
    pkt.delete();
    for (int i = 0; i < 4; i++)
      pkt.push_back(i[0] ? 8'h3F : 8'hFF);
    send_packet();
    wait_count(4);
    read_packet(4, 1'b1);
    finish_test();

    test_name = "stuff_error";
    begin_packet();
    repeat (7) emit_bit(1'b1, 1'b0);  // no stuffing
    end_packet();
    wait_count(1);
    bus_cycle(1'b0, ADR_STATUS, '0, rd);
    check_value("status", status_word(1, 1'b1, 1'b1, 1'b0), rd);
    bus_cycle(1'b0, ADR_DATA, '0, rd);
    check_value("error entry", entry_word(8'h00, 1'b1, 1'b1), rd);
    fill_random(3);
    send_packet();
    wait_count(3);
    read_packet(3, 1'b1);
    finish_test();

    test_name = "overflow";
    fill_random(10);
    send_packet();
    wait_count(8);
    bus_cycle(1'b0, ADR_STATUS, '0, rd);
    check_value("full status", status_word(8, 1'b0, 1'b0, 1'b1), rd);
    read_packet(8, 1'b0);
    bus_cycle(1'b1, ADR_STATUS, 32'h0000_0001, rd);
    bus_cycle(1'b0, ADR_STATUS, '0, rd);
    check_value("cleared status", status_word(0, 1'b0, 1'b0, 1'b0), rd);
    finish_test();

    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests, failed, errors, DUT.u_props.fail_count);
    if (errors == 0 && DUT.u_props.fail_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* usb_rx_properties.sv */
//**************************************************************************
// Bus and push rules for usb_rx_top, attached by bind.
// fail_count is read by the testbench at the end of the run.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module usb_rx_properties (
  input logic               clk,
  input logic               reset,
  input logic               cyc,
  input logic               stb,
  input logic               ack,
  input logic               push,
  input usb_pkg::rx_state_t state
);

  int unsigned fail_count = 0;

  ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
  else
  begin
    $error("wishbone ack held for more than one clock");
    fail_count++;
  end

  ack_after_request: assert property (@(posedge clk) disable iff (reset)
    ack |-> $past(cyc && stb))
  else
  begin
    $error("wishbone ack without a preceding cyc and stb");
    fail_count++;
  end

  // entries only come from data, eop or error handling
  no_push_in_idle: assert property (@(posedge clk) disable iff (reset)
    push |-> (state != usb_pkg::RX_IDLE))
  else
  begin
    $error("fifo push while the receiver is idle");
    fail_count++;
  end

endmodule

bind usb_rx_top usb_rx_properties u_props (
  .clk(clk), .reset(reset), .cyc(wb_cyc), .stb(wb_stb), .ack(wb_ack),
  .push(push), .state(rx_state)
);

`default_nettype wire

/* usb_tb_clock.sv */
//**************************************************************************
// Testbench clock, 8 ns period. reset is high for the first 3 edges.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module usb_tb_clock (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;  // released on the clock edge
  end

endmodule

`default_nettype wire

/* usb_rx_top.sv */
//**************************************************************************
// USB full-speed receiver with a Wishbone read port. 48 MHz clk assumed.
// No transmitter, PID or CRC checks; rx_state is exported for checkers.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "usb_params.svh"

module usb_rx_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   usb_p,
  input  logic                   usb_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [`WB_ADDR_W-1:0]  wb_adr,
  input  logic [`WB_DATA_W-1:0]  wb_dat_w,
  output logic [`WB_DATA_W-1:0]  wb_dat_r,
  output logic                   wb_ack
);

  usb_pkg::usb_line_t line;
  usb_pkg::rx_state_t rx_state;
  usb_pkg::rx_entry_t wr_entry;
  usb_pkg::rx_entry_t head;
  logic               sample;
  logic               start;
  logic               bit_en;
  logic               flush;
  logic               abort;
  logic               byte_done;
  logic               stuff_err;
  logic               sync_ok;
  logic               push;
  logic               pop;
  logic [3:0]         fifo_count;
  logic               overflow;
  logic               clear_overflow;

  usb_line_sync u_sync (.clk, .reset, .usb_p, .usb_n, .line);

  usb_bit_timer u_timer (.clk, .reset, .line, .sample);

  usb_rx_fsm u_fsm (
    .clk, .reset, .line, .sample, .byte_done, .stuff_err, .sync_ok,
    .start, .bit_en, .flush, .abort, .state(rx_state)
  );

  usb_nrzi_decoder u_dec (
    .clk, .reset, .line_code(line.code), .start, .bit_en, .flush, .abort,
    .byte_done, .stuff_err, .sync_ok, .push, .entry(wr_entry)
  );

  usb_rx_fifo #(.entry_t(usb_pkg::rx_entry_t), .DEPTH(`USB_FIFO_DEPTH)) u_fifo (
    .clk, .reset, .push, .wdata(wr_entry), .pop, .head,
    .count(fifo_count), .overflow, .clear_overflow
  );

  usb_wb_regs u_regs (
    .clk, .reset, .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr),
    .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack), .head,
    .count(fifo_count), .overflow, .pop, .clear_overflow
  );

endmodule

`default_nettype wire

/* usb_wb_regs.sv */
//**************************************************************************
// Wishbone classic slave, ack one clock after the request, one clock long.
// adr 0 status (write clears overflow), adr 1 data with pop on read.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "usb_params.svh"

module usb_wb_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic [`WB_ADDR_W-1:0]  adr,
  input  logic [`WB_DATA_W-1:0]  dat_w,  // ignored, any write clears
  output logic [`WB_DATA_W-1:0]  dat_r,
  output logic                   ack,
  input  usb_pkg::rx_entry_t     head,
  input  logic [3:0]             count,
  input  logic                   overflow,
  output logic                   pop,
  output logic                   clear_overflow
);

  localparam logic [`WB_ADDR_W-1:0] ADR_STATUS = 0;
  localparam logic [`WB_ADDR_W-1:0] ADR_DATA   = 1;

  usb_pkg::rx_status_t status;
  logic                access;  // first clock of a cycle
  logic                nonempty;

  assign access   = cyc && stb && !ack;
  assign nonempty = (count != 4'd0);

  always_comb
  begin
    status           = '0;
    status.count     = count;
    status.nonempty  = nonempty;
    status.head_last = nonempty && head.last;
    status.head_err  = nonempty && head.err;
    status.overflow  = overflow;
  end

  assign pop            = access && !we && (adr == ADR_DATA) && nonempty;
  assign clear_overflow = access && we && (adr == ADR_STATUS);

  always_ff @(posedge clk)
  begin
    if (reset)
      ack <= 1'b0;
    else
      ack <= access;
  end

  // head is captured on the same edge that pops it
  always_ff @(posedge clk)
  begin
    if (access && !we)
    begin
      if (adr == ADR_STATUS)
        dat_r <= status;
      else if (adr == ADR_DATA && nonempty)
        dat_r <= {{(`WB_DATA_W - $bits(usb_pkg::rx_entry_t)){1'b0}}, head};
      else
        dat_r <= '0;  // empty or unmapped
    end
  end

endmodule

`default_nettype wire

/* usb_rx_fifo.sv */
//**************************************************************************
// Synchronous FIFO with a combinational head. DEPTH must be a power of
// two. A push while full is dropped and sets the sticky overflow flag.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "usb_params.svh"

module usb_rx_fifo #(
  parameter type entry_t = usb_pkg::rx_entry_t,
  parameter int  DEPTH   = `USB_FIFO_DEPTH
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push,
  input  entry_t                       wdata,
  input  logic                         pop,
  output entry_t                       head,
  output logic [$clog2(DEPTH+1)-1:0]   count,
  output logic                         overflow,
  input  logic                         clear_overflow
);

  localparam int PTR_W = $clog2(DEPTH);

  entry_t           mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == DEPTH);
  assign do_push = push && !full;
  assign do_pop  = pop && (count != '0);
  assign head    = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + do_push - do_pop;
      if (push && full)
        overflow <= 1'b1;  // a new drop wins over a clear
      else if (clear_overflow)
        overflow <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= wdata;
  end

endmodule

`default_nettype wire

/* usb_nrzi_decoder.sv */
//**************************************************************************
// NRZI decode, destuffing and LSB-first byte assembly.
// A finished byte waits in a hold register until the next byte, flush or
// abort sets its flags. The first byte after start is sync, never pushed.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "usb_params.svh"

module usb_nrzi_decoder (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [1:0]           line_code,
  input  logic                 start,
  input  logic                 bit_en,
  input  logic                 flush,
  input  logic                 abort,
  output logic                 byte_done,
  output logic                 stuff_err,
  output logic                 sync_ok,
  output logic                 push,
  output usb_pkg::rx_entry_t   entry
);

  logic [1:0] ref_code;    // previous bit's line code
  logic [2:0] ones;        // consecutive ones
  logic [2:0] nbit;
  logic [7:0] shift;
  logic [7:0] hold;
  logic       hold_valid;
  logic       first;       // next byte is sync
  logic       bit_one;
  logic       stuff_slot;
  logic [7:0] next_shift;

  assign bit_one    = (line_code == ref_code);  // no transition means 1
  assign stuff_slot = (ones == 3'd6);
  assign next_shift = {bit_one, shift[7:1]};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ref_code <= `LINE_J;
      ones <= '0;
      nbit <= '0;
      first <= 1'b0;
      hold_valid <= 1'b0;
      byte_done <= 1'b0;
      stuff_err <= 1'b0;
      sync_ok <= 1'b0;
      push <= 1'b0;
    end
    else
    begin
      byte_done <= 1'b0;
      stuff_err <= 1'b0;
      push      <= 1'b0;
      if (start)
      begin
        ref_code <= `LINE_J;
        ones <= '0;
        nbit <= '0;
        first <= 1'b1;
        sync_ok <= 1'b0;
        hold_valid <= 1'b0;
      end
      else if (bit_en)
      begin
        ref_code <= line_code;
        if (stuff_slot)
        begin
          if (bit_one)
            stuff_err <= 1'b1;  // seventh one
          else
            ones <= '0;  // stuffed zero dropped
        end
        else
        begin
          ones <= bit_one ? ones + 1'b1 : 3'd0;
          nbit <= nbit + 1'b1;
          if (nbit == 3'd7)
          begin
            byte_done <= 1'b1;
            if (first)
              sync_ok <= (next_shift == 8'h80);
          end
        end
      end
      if (abort)
      begin
        push <= 1'b1;  // always leave an error marker
        hold_valid <= 1'b0;
      end
      else if (flush)
      begin
        push <= hold_valid;
        hold_valid <= 1'b0;
      end
      else if (byte_done && !first)
      begin
        push <= hold_valid;  // previous byte is not last
        hold_valid <= 1'b1;
      end
      if (byte_done)
        first <= 1'b0;
    end
  end

  // data path, no reset
  always_ff @(posedge clk)
  begin
    if (bit_en && !stuff_slot)
      shift <= next_shift;
    if (byte_done && !first)
      hold <= shift;
    entry.data <= (abort && !hold_valid) ? 8'h00 : hold;
    entry.last <= abort || flush;
    entry.err  <= abort;
  end

endmodule

`default_nettype wire

/* usb_rx_fsm.sv */
//**************************************************************************
// Packet phase sequencer. Commands to the decoder are one-clock pulses.
// Keeps its own count of ones so a stuffed bit before EOP is not taken
// as data. EOP is SE0, SE0, J; the FSM leaves EOP one clock after flush.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "usb_params.svh"

module usb_rx_fsm (
  input  logic                 clk,
  input  logic                 reset,
  input  usb_pkg::usb_line_t   line,
  input  logic                 sample,
  input  logic                 byte_done,
  input  logic                 stuff_err,
  input  logic                 sync_ok,
  output logic                 start,
  output logic                 bit_en,
  output logic                 flush,
  output logic                 abort,
  output usb_pkg::rx_state_t   state
);

  logic [1:0] last_code;  // previous bit's line code
  logic [2:0] ones;       // run of ones, mirrors the decoder
  logic       at_byte;    // no data bit since the last byte_done
  logic [1:0] eop_cnt;    // 0 second SE0, 1 J, 2 leaving
  logic       line_ok;
  logic       is_se0;
  logic       eop_ok;

  assign line_ok = line.valid && (line.code != `LINE_SE1);
  assign is_se0  = (line.code == `LINE_Z);
  assign eop_ok  = line_ok && (line.code == ((eop_cnt == 2'd0) ? `LINE_Z : `LINE_J));

  always_comb
  begin
    start  = 1'b0;
    bit_en = 1'b0;
    flush  = 1'b0;
    abort  = 1'b0;
    case (state)
      usb_pkg::RX_IDLE:
        start = line_ok && (line.code == `LINE_K);
      usb_pkg::RX_SYNC:
        bit_en = sample && line_ok && !is_se0;
      usb_pkg::RX_DATA:
      begin
        bit_en = sample && line_ok && !is_se0;
        abort  = stuff_err || (sample && (!line_ok || (is_se0 && !at_byte)));
      end
      usb_pkg::RX_EOP:
      begin
        flush = sample && (eop_cnt == 2'd1) && eop_ok;
        abort = sample && (eop_cnt != 2'd2) && !eop_ok;
      end
      default: ;
    endcase
  end

  // bit and byte boundary tracking
  always_ff @(posedge clk)
  begin
    if (reset || start)
    begin
      last_code <= `LINE_J;  // NRZI reference before sync
      ones      <= '0;
      at_byte   <= 1'b0;
    end
    else if (bit_en)
    begin
      last_code <= line.code;
      ones      <= (line.code == last_code) ? ones + 1'b1 : 3'd0;
      if (ones != 3'd6)
        at_byte <= 1'b0;  // stuffed bits do not count
    end
    else if (byte_done)
      at_byte <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state   <= usb_pkg::RX_RESET;
      eop_cnt <= '0;
    end
    else
    begin
      case (state)
        usb_pkg::RX_RESET:
          if (line_ok && line.code == `LINE_J)
            state <= usb_pkg::RX_IDLE;
        usb_pkg::RX_IDLE:
          if (start)
            state <= usb_pkg::RX_SYNC;
        usb_pkg::RX_SYNC:
          if (sample && (!line_ok || is_se0))
            state <= usb_pkg::RX_ERROR;
          else if (byte_done)
            state <= sync_ok ? usb_pkg::RX_DATA : usb_pkg::RX_ERROR;
        usb_pkg::RX_DATA:
          if (abort)
            state <= usb_pkg::RX_ERROR;
          else if (sample && is_se0)
          begin
            state   <= usb_pkg::RX_EOP;  // first SE0 at a byte boundary
            eop_cnt <= 2'd0;
          end
        usb_pkg::RX_EOP:
          if (eop_cnt == 2'd2)
            state <= usb_pkg::RX_IDLE;  // push from flush lands here
          else if (abort)
            state <= usb_pkg::RX_ERROR;
          else if (sample)
            eop_cnt <= eop_cnt + 1'b1;
        usb_pkg::RX_ERROR:
          if (line_ok && is_se0)
            state <= usb_pkg::RX_RESET;
        default:
          state <= usb_pkg::RX_RESET;
      endcase
    end
  end

endmodule

`default_nettype wire

/* usb_bit_timer.sv */
//**************************************************************************
// Free-running bit counter that restarts on every line code change.
// sample fires once per bit, never on the clock of an edge.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "usb_params.svh"

module usb_bit_timer (
  input  logic                 clk,
  input  logic                 reset,
  input  usb_pkg::usb_line_t   line,
  output logic                 sample
);

  localparam int CNT_W = $clog2(`USB_OVERSAMPLE);

  logic [CNT_W-1:0] cnt;
  logic [1:0]       last_code;  // code seen on the previous clock
  logic             edge_seen;

  assign edge_seen = (line.code != last_code);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cnt       <= '0;
      last_code <= `LINE_Z;  // matches the synchronizer reset value
    end
    else
    begin
      last_code <= line.code;
      if (edge_seen || cnt == CNT_W'(`USB_OVERSAMPLE - 1))
        cnt <= '0;  // re-align or wrap
      else
        cnt <= cnt + 1'b1;
    end
  end

  // mid-bit strobe
  assign sample = (cnt == CNT_W'(`USB_SAMPLE_PHASE)) && !edge_seen;

endmodule

`default_nettype wire

/* usb_line_sync.sv */
//**************************************************************************
// Three flops per pin. The output lags the pins by three clocks.
// valid only means both pins held still over the last two samples.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module usb_line_sync (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 usb_p,
  input  logic                 usb_n,
  output usb_pkg::usb_line_t   line
);

  logic [2:0] dp;  // D+ shift register, [2] is oldest
  logic [2:0] dn;  // D- shift register

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      dp <= '0;  // reads as SE0 until the pins arrive
      dn <= '0;
    end
    else
    begin
      dp <= {dp[1:0], usb_p};
      dn <= {dn[1:0], usb_n};
    end
  end

  always_comb
  begin
    line.code  = {dp[2], dn[2]};
    line.valid = (dp[2] == dp[1]) && (dn[2] == dn[1]);  // no edge in flight
  end

endmodule

`default_nettype wire

/* usb_pkg.sv */
//**************************************************************************
// Types shared by the receive path and the bus registers.
// rx_status_t is exactly one Wishbone data word wide.
//**************************************************************************
`default_nettype none

`include "usb_params.svh"

package usb_pkg;

  typedef struct packed {
    logic [1:0] code;   // {D+, D-}
    logic       valid;  // both pins stable over two samples
  } usb_line_t;

  typedef struct packed {
    logic       err;   // packet aborted
    logic       last;  // final byte of a packet
    logic [7:0] data;
  } rx_entry_t;

  typedef struct packed {
    logic [`WB_DATA_W-9:0] zero;
    logic                  overflow;   // sticky, cleared by a status write
    logic                  head_err;
    logic                  head_last;
    logic                  nonempty;
    logic [3:0]            count;
  } rx_status_t;

  typedef enum logic [2:0] {
    RX_RESET,
    RX_IDLE,
    RX_SYNC,
    RX_DATA,
    RX_EOP,
    RX_ERROR
  } rx_state_t;

endpackage

`default_nettype wire

/* usb_params.svh */
//**************************************************************************
// Full-speed receive only. Line codes carry D+ in the upper bit.
// USB_FIFO_DEPTH must be a power of two, and the status count field
// is four bits wide, so depths above 8 need a wider status word.
//**************************************************************************
`ifndef USB_PARAMS_SVH
`define USB_PARAMS_SVH

// line codes {D+, D-}
`define LINE_J   2'b10  // idle state
`define LINE_K   2'b01
`define LINE_Z   2'b00  // SE0
`define LINE_SE1 2'b11  // illegal on the bus

`define USB_OVERSAMPLE   4  // 48 MHz clocks per 12 Mb/s bit
`define USB_SAMPLE_PHASE 1  // timer count where a bit is taken

`define USB_FIFO_DEPTH 8

`define WB_DATA_W 32
`define WB_ADDR_W 2  // word address

`endif
